// ==== common/procPkg.sv ====
package procPkg;

   // opcode lives in inst[15:11], anything not listed here is undefined
   typedef enum logic [4:0] {
      NOP  = 5'd0,
      HALT = 5'd1,
      ADD  = 5'd2,
      SUB  = 5'd3,
      AND  = 5'd4,
      XOR  = 5'd5,
      ADDI = 5'd6,
      LD   = 5'd7,
      ST   = 5'd8,
      BEQZ = 5'd9,
      BNEZ = 5'd10,
      J    = 5'd11
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB  // second operand straight through
   } aluOpT;

   // instruction field positions
   localparam int OP_HI    = 15;
   localparam int OP_LO    = 11;
   localparam int RS_HI    = 10;
   localparam int RS_LO    = 8;
   localparam int RT_HI    = 7;   // also rd of I-format
   localparam int RT_LO    = 5;
   localparam int RD_HI    = 4;   // R-format only
   localparam int RD_LO    = 2;
   localparam int IMM5_HI  = 4;
   localparam int IMM8_HI  = 7;
   localparam int IMM11_HI = 10;

   typedef struct packed {
      aluOpT aluOp;
      logic  aluSrcImm;
      logic  memRead;
      logic  memWrite;
      logic  regWrite;
      logic  isBeqz;
      logic  isBnez;
      logic  isJump;
      logic  isHalt;
   } ctrlT;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc2;
      logic [15:0] inst;
   } ifIdT;

   typedef struct packed {
      logic        valid;
      ctrlT        ctrl;
      logic [15:0] pc2;
      logic [2:0]  rd;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm;
   } idExT;

   typedef struct packed {
      logic        valid;
      ctrlT        ctrl;
      logic [15:0] pc2;
      logic [2:0]  rd;
      logic [15:0] aluOut;
      logic [15:0] storeData;
      logic [15:0] target;
   } exMemT;

   typedef struct packed {
      logic        valid;
      logic        regWrite;
      logic        isHalt;
      logic [2:0]  rd;
      logic [15:0] data;
   } memWbT;

   typedef struct packed {
      logic        valid;
      logic [2:0]  rd;
      logic [15:0] data;
   } retireT;

endpackage

// ==== fetch/instMem.sv ====
`timescale 1ns/1ps
module instMem #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          loadEn,
   input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,  // word index
   input  logic [15:0]                   loadData,
   input  logic [15:0]                   rdAddr,    // byte address from the PC
   output logic [15:0]                   rdData
);
   localparam int AW = $clog2(IMEM_WORDS);

   logic [15:0] mem [IMEM_WORDS];

   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

   // bit 0 of the PC is always zero
   assign rdData = mem[rdAddr[AW:1]];

   // a load must land while the PC is still parked at zero by reset
   assert property (@(posedge clk) loadEn |=> rdAddr == '0);

endmodule

// ==== fetch/fetchStage.sv ====
`timescale 1ns/1ps
module fetchStage #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          stall,
   input  logic                          redirect,
   input  logic [15:0]                   redirectPc,
   input  logic                          loadEn,
   input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
   input  logic [15:0]                   loadData,
   output procPkg::ifIdT                 ifId
);
   logic [15:0] pc;
   logic [15:0] pcPlus2;
   logic [15:0] inst;

   assign pcPlus2 = pc + 16'd2;

   instMem #(.IMEM_WORDS(IMEM_WORDS)) instMem_i (
      .clk      (clk),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .rdAddr   (pc),
      .rdData   (inst)
   );

   // redirect beats stall, stall beats sequential
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall) begin
         pc <= pcPlus2;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ifId.pc2  <= pcPlus2;
         ifId.inst <= inst;
      end
      if (!rstN) begin
         ifId.valid <= 1'b0;
      end else if (redirect) begin
         ifId.valid <= 1'b0;  // wrong-path slot
      end else if (!stall) begin
         ifId.valid <= 1'b1;
      end
   end

endmodule

// ==== decode/regFile.sv ====
`timescale 1ns/1ps
module regFile (
   input  logic        clk,
   input  logic        rstN,
   input  logic        we,
   input  logic [2:0]  wAddr,
   input  logic [15:0] wData,
   input  logic [2:0]  rAddr1,
   input  logic [2:0]  rAddr2,
   output logic [15:0] rData1,
   output logic [15:0] rData2
);
   // r0 is a normal register here
   logic [15:0] regs [8];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (we) begin
         regs[wAddr] <= wData;
      end
   end

   // write-through so a same-cycle read sees the new value
   assign rData1 = (we && wAddr == rAddr1) ? wData : regs[rAddr1];
   assign rData2 = (we && wAddr == rAddr2) ? wData : regs[rAddr2];

endmodule

// ==== decode/decodeStage.sv ====
`timescale 1ns/1ps
module decodeStage (
   input  logic           clk,
   input  logic           rstN,
   input  procPkg::ifIdT  ifId,
   input  logic           flush,
   input  procPkg::memWbT memWb,
   output procPkg::idExT  idEx,
   output logic           stall,
   output logic           err,
   output logic           halting
);
   procPkg::opcodeT opcode;
   procPkg::ctrlT   ctrl;
   logic [2:0]      rs;
   logic [2:0]      rt;
   logic [2:0]      rd;
   logic [2:0]      rAddr2;
   logic [15:0]     imm;
   logic [15:0]     rData1;
   logic [15:0]     rData2;
   logic            usesRs;
   logic            usesRt;
   logic            illegal;
   logic            hazard;
   logic            exWrValid;  // shadow of what EX/MEM will write
   logic [2:0]      exWrRd;

   function automatic logic srcBusy(input logic [2:0] src);
      return (idEx.valid && idEx.ctrl.regWrite && idEx.rd == src) ||
             (exWrValid && exWrRd == src) ||
             (memWb.valid && memWb.regWrite && memWb.rd == src);
   endfunction

   assign opcode = procPkg::opcodeT'(ifId.inst[procPkg::OP_HI:procPkg::OP_LO]);
   assign rs     = ifId.inst[procPkg::RS_HI:procPkg::RS_LO];
   assign rt     = ifId.inst[procPkg::RT_HI:procPkg::RT_LO];
   assign rAddr2 = (ctrl.isBeqz || ctrl.isBnez) ? rs : rt;  // branches test rs through b

   always_comb begin
      ctrl    = '0;
      ctrl.aluOp = procPkg::ALU_ADD;
      rd      = rt;
      imm     = {{11{ifId.inst[procPkg::IMM5_HI]}}, ifId.inst[procPkg::IMM5_HI:0]};
      usesRs  = 1'b0;
      usesRt  = 1'b0;
      illegal = 1'b0;
      case (opcode)
         procPkg::NOP: ;
         procPkg::HALT: ctrl.isHalt = 1'b1;
         procPkg::ADD, procPkg::SUB, procPkg::AND, procPkg::XOR: begin
            ctrl.aluOp    = (opcode == procPkg::SUB) ? procPkg::ALU_SUB :
                            (opcode == procPkg::AND) ? procPkg::ALU_AND :
                            (opcode == procPkg::XOR) ? procPkg::ALU_XOR : procPkg::ALU_ADD;
            ctrl.regWrite = 1'b1;
            rd     = ifId.inst[procPkg::RD_HI:procPkg::RD_LO];
            usesRs = 1'b1;
            usesRt = 1'b1;
         end
         procPkg::ADDI, procPkg::LD: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.memRead   = (opcode == procPkg::LD);
            usesRs = 1'b1;
         end
         procPkg::ST: begin
            ctrl.aluSrcImm = 1'b1;  // rs + imm5
            ctrl.memWrite  = 1'b1;
            usesRs = 1'b1;
            usesRt = 1'b1;
         end
         procPkg::BEQZ, procPkg::BNEZ: begin
            ctrl.aluOp  = procPkg::ALU_PASSB;
            ctrl.isBeqz = (opcode == procPkg::BEQZ);
            ctrl.isBnez = (opcode == procPkg::BNEZ);
            imm    = {{8{ifId.inst[procPkg::IMM8_HI]}}, ifId.inst[procPkg::IMM8_HI:0]};
            usesRs = 1'b1;
         end
         procPkg::J: begin
            ctrl.aluOp  = procPkg::ALU_PASSB;
            ctrl.isJump = 1'b1;
            imm = {{5{ifId.inst[procPkg::IMM11_HI]}}, ifId.inst[procPkg::IMM11_HI:0]};
         end
         default: illegal = 1'b1;
      endcase
   end

   always_comb begin
      hazard = (usesRs && srcBusy(rs)) || (usesRt && srcBusy(rt));
      stall  = !flush && (halting || (ifId.valid && hazard));
   end

   regFile regFile_i (
      .clk    (clk),
      .rstN   (rstN),
      .we     (memWb.valid && memWb.regWrite),
      .wAddr  (memWb.rd),
      .wData  (memWb.data),
      .rAddr1 (rs),
      .rAddr2 (rAddr2),
      .rData1 (rData1),
      .rData2 (rData2)
   );

   always_ff @(posedge clk) begin
      idEx.ctrl <= ctrl;
      idEx.pc2  <= ifId.pc2;
      idEx.rd   <= rd;
      idEx.a    <= rData1;
      idEx.b    <= rData2;
      idEx.imm  <= imm;
      exWrRd    <= idEx.rd;
      if (!rstN) begin
         idEx.valid <= 1'b0;
         exWrValid  <= 1'b0;
         halting    <= 1'b0;
         err        <= 1'b0;
      end else begin
         idEx.valid <= ifId.valid && !illegal && !stall && !flush;  // else a bubble
         exWrValid  <= !flush && idEx.valid && idEx.ctrl.regWrite;
         if (flush) begin
            halting <= 1'b0;  // that HALT was on the wrong path
         end else if (ifId.valid && ctrl.isHalt) begin
            halting <= 1'b1;
         end
         if (ifId.valid && illegal && !halting && !flush) begin
            err <= 1'b1;
         end
      end
   end

   // fetch must honour a stall and a flush, never mix the two
   assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(ifId));

   assert property (@(posedge clk) disable iff (!rstN) flush |=> !ifId.valid);

endmodule

// ==== execute/executeStage.sv ====
`timescale 1ns/1ps
module executeStage (
   input  logic           clk,
   input  logic           rstN,
   input  procPkg::idExT  idEx,
   input  logic           flush,
   output procPkg::exMemT exMem
);
   logic [15:0] opB;
   logic [15:0] aluOut;
   logic [15:0] target;

   always_comb begin
      opB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.b;
      case (idEx.ctrl.aluOp)
         procPkg::ALU_ADD:   aluOut = idEx.a + opB;
         procPkg::ALU_SUB:   aluOut = idEx.a - opB;
         procPkg::ALU_AND:   aluOut = idEx.a & opB;
         procPkg::ALU_XOR:   aluOut = idEx.a ^ opB;
         procPkg::ALU_PASSB: aluOut = opB;
         default:            aluOut = '0;
      endcase
   end

   // branch and jump target, relative to the next instruction
   assign target = idEx.pc2 + idEx.imm;

   always_ff @(posedge clk) begin
      exMem.ctrl      <= idEx.ctrl;
      exMem.pc2       <= idEx.pc2;
      exMem.rd        <= idEx.rd;
      exMem.aluOut    <= aluOut;
      exMem.storeData <= idEx.b;  // rt for ST, rs for branches
      exMem.target    <= target;
      if (!rstN) begin
         exMem.valid <= 1'b0;
      end else begin
         exMem.valid <= idEx.valid && !flush;
      end
   end

endmodule

// ==== memory/memStage.sv ====
`timescale 1ns/1ps
module memStage #(
   parameter int DMEM_WORDS = 256
) (
   input  logic           clk,
   input  logic           rstN,
   input  procPkg::exMemT exMem,
   output procPkg::memWbT memWb,
   output logic           redirect,
   output logic [15:0]    redirectPc,
   output logic           flush,
   output logic           halted
);
   localparam int AW = $clog2(DMEM_WORDS);

   logic [15:0] dmem [DMEM_WORDS];
   logic [15:0] loadData;
   logic        rsZero;
   logic        taken;

   assign loadData = dmem[exMem.aluOut[AW:1]];

   always_ff @(posedge clk) begin
      if (exMem.valid && exMem.ctrl.memWrite) begin
         dmem[exMem.aluOut[AW:1]] <= exMem.storeData;
      end
   end

   assign rsZero = (exMem.storeData == '0);
   assign taken  = exMem.valid && ((exMem.ctrl.isBeqz && rsZero) ||
                                   (exMem.ctrl.isBnez && !rsZero) || exMem.ctrl.isJump);

   assign redirect   = taken;
   assign redirectPc = exMem.target;
   assign flush      = taken;  // kills the three younger slots

   always_ff @(posedge clk) begin
      memWb.regWrite <= exMem.ctrl.regWrite;
      memWb.isHalt   <= exMem.ctrl.isHalt;
      memWb.rd       <= exMem.rd;
      memWb.data     <= exMem.ctrl.memRead ? loadData : exMem.aluOut;
      if (!rstN) begin
         memWb.valid <= 1'b0;
         halted      <= 1'b0;
      end else begin
         memWb.valid <= exMem.valid;
         if (exMem.valid && exMem.ctrl.isHalt) begin
            halted <= 1'b1;  // same edge HALT enters MEM/WB
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rstN)
      exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite) |-> !exMem.aluOut[0]);

endmodule

// ==== hdl/proc.sv ====
`timescale 1ns/1ps
module proc #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          loadEn,
   input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
   input  logic [15:0]                   loadData,
   output procPkg::retireT               retire,
   output logic                          halted,
   output logic                          err
);
   procPkg::ifIdT  ifId;
   procPkg::idExT  idEx;
   procPkg::exMemT exMem;
   procPkg::memWbT memWb;
   logic           stall;
   logic           redirect;
   logic [15:0]    redirectPc;
   logic           flush;
   logic           halting;

   fetchStage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .loadEn     (loadEn),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .ifId       (ifId)
   );

   decodeStage decode_i (
      .clk     (clk),
      .rstN    (rstN),
      .ifId    (ifId),
      .flush   (flush),
      .memWb   (memWb),
      .idEx    (idEx),
      .stall   (stall),
      .err     (err),
      .halting (halting)
   );

   executeStage execute_i (
      .clk   (clk),
      .rstN  (rstN),
      .idEx  (idEx),
      .flush (flush),
      .exMem (exMem)
   );

   memStage #(.DMEM_WORDS(DMEM_WORDS)) mem_i (
      .clk        (clk),
      .rstN       (rstN),
      .exMem      (exMem),
      .memWb      (memWb),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .flush      (flush),
      .halted     (halted)
   );

   // only real register writes show up as retires
   assign retire.valid = memWb.valid && memWb.regWrite;
   assign retire.rd    = memWb.rd;
   assign retire.data  = memWb.data;

   // nothing younger than HALT may reach MEM and cancel the halt
   assert property (@(posedge clk) disable iff (!rstN) halted |-> halting);

endmodule

// ==== dv/procTb.sv ====
`timescale 1ns/1ps
module procTb;
   localparam int IMEM_WORDS  = 256;
   localparam int DMEM_WORDS  = 256;
   localparam int RUN_TIMEOUT = 600;  // cycles from reset release to halted
   localparam int HALT_WINDOW = 20;

   logic                          clk = 1'b0;
   logic                          rstN;
   logic                          loadEn;
   logic [$clog2(IMEM_WORDS)-1:0] loadAddr;
   logic [15:0]                   loadData;
   procPkg::retireT               retire;
   logic                          halted;
   logic                          err;

   logic [31:0] seed = 32'hce17;
   logic [15:0] prog [$];
   logic [2:0]  expRd [$];
   logic [15:0] expData [$];
   logic [15:0] sh [8];           // architectural register view
   logic [15:0] dm [DMEM_WORDS];  // data memory view, word indexed

   proc #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut_i (
      .clk      (clk),
      .rstN     (rstN),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .retire   (retire),
      .halted   (halted),
      .err      (err)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcgNext();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [4:0] rand5();
      logic [31:0] r;
      r = lcgNext();
      return r[20:16];  // upper bits are the better ones
   endfunction

   function automatic logic [15:0] sext5(input logic [4:0] imm);
      return {{11{imm[4]}}, imm};
   endfunction

   function automatic logic [15:0] encR(input procPkg::opcodeT op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic logic [15:0] encI(input procPkg::opcodeT op, input logic [2:0] rt,
                                        input logic [2:0] rs, input logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic stopRun();
      $display("TB FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         stopRun();
      end
   endtask

   task automatic startTest();
      prog.delete();
      expRd.delete();
      expData.delete();
      for (int i = 0; i < 8; i++) begin
         sh[i] = '0;  // reset clears the register file
      end
   endtask

   task automatic expectWrite(input logic [2:0] rd, input logic [15:0] val);
      expRd.push_back(rd);
      expData.push_back(val);
      sh[rd] = val;
   endtask

   task automatic emitR(input procPkg::opcodeT op, input logic [2:0] rd,
                        input logic [2:0] rs, input logic [2:0] rt);
      logic [15:0] res;
      case (op)
         procPkg::ADD: res = sh[rs] + sh[rt];
         procPkg::SUB: res = sh[rs] - sh[rt];
         procPkg::AND: res = sh[rs] & sh[rt];
         default:      res = sh[rs] ^ sh[rt];
      endcase
      prog.push_back(encR(op, rd, rs, rt));
      expectWrite(rd, res);
   endtask

   task automatic emitAddi(input logic [2:0] rd, input logic [2:0] rs, input logic [4:0] imm);
      prog.push_back(encI(procPkg::ADDI, rd, rs, imm));
      expectWrite(rd, sh[rs] + sext5(imm));
   endtask

   // instruction on a path that must never execute
   task automatic deadAddi(input logic [2:0] rd, input logic [2:0] rs, input logic [4:0] imm);
      prog.push_back(encI(procPkg::ADDI, rd, rs, imm));
   endtask

   task automatic pathAddi(input logic skipped, input logic [2:0] rd, input logic [2:0] rs,
                           input logic [4:0] imm);
      if (skipped) begin
         deadAddi(rd, rs, imm);
      end else begin
         emitAddi(rd, rs, imm);
      end
   endtask

   task automatic emitSt(input logic [2:0] rt, input logic [2:0] rs, input logic [4:0] imm);
      logic [15:0] addr;
      addr = sh[rs] + sext5(imm);
      dm[addr[8:1]] = sh[rt];  // byte address to word index
      prog.push_back(encI(procPkg::ST, rt, rs, imm));
   endtask

   task automatic emitLd(input logic [2:0] rd, input logic [2:0] rs, input logic [4:0] imm);
      logic [15:0] addr;
      addr = sh[rs] + sext5(imm);
      prog.push_back(encI(procPkg::LD, rd, rs, imm));
      expectWrite(rd, dm[addr[8:1]]);
   endtask

   // offset skips a number of instructions past the next one
   task automatic emitBranch(input procPkg::opcodeT op, input logic [2:0] rs, input int skip,
                             output logic taken);
      logic [7:0] off;
      off   = 8'(2 * skip);
      taken = (op == procPkg::BEQZ) ? (sh[rs] == '0) : (sh[rs] != '0);
      prog.push_back({op, rs, off});
   endtask

   task automatic emitJump(input int skip);
      logic [10:0] off;
      off = 11'(2 * skip);
      prog.push_back({procPkg::J, off});
   endtask

   task automatic emitHalt();
      prog.push_back({procPkg::HALT, 11'd0});
   endtask

   task automatic emitNop();
      prog.push_back({procPkg::NOP, 11'd0});
   endtask

   task automatic runProgram(input string name, input logic expErr);
      int idx;
      int cycles;
      idx    = 0;
      cycles = 0;
      @(negedge clk);
      rstN = 1'b0;
      foreach (prog[i]) begin
         @(negedge clk);
         loadEn   = 1'b1;
         loadAddr = i[$clog2(IMEM_WORDS)-1:0];
         loadData = prog[i];
      end
      @(negedge clk);
      loadEn = 1'b0;
      repeat (4) @(negedge clk);
      check({name, " retire.valid in reset"}, retire.valid, 1'b0);
      check({name, " halted in reset"}, halted, 1'b0);
      check({name, " err in reset"}, err, 1'b0);
      rstN = 1'b1;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > RUN_TIMEOUT) begin
            $display("%s: halted did not rise within %0d cycles", name, RUN_TIMEOUT);
            stopRun();
         end else if (retire.valid) begin
            if (idx >= expRd.size()) begin
               $display("%s: a retire arrived after all expected ones", name);
               stopRun();
            end else begin
               check({name, " retire.rd"}, retire.rd, expRd[idx]);
               check({name, " retire.data"}, retire.data, expData[idx]);
               idx++;
            end
         end
      end while (!halted);
      check({name, " retire count"}, idx, expRd.size());
      for (int w = 0; w < HALT_WINDOW; w++) begin
         @(negedge clk);
         check({name, " retire.valid after halt"}, retire.valid, 1'b0);
         check({name, " halted"}, halted, 1'b1);
      end
      check({name, " err"}, err, expErr);
   endtask

   task automatic testAlu();
      startTest();
      emitAddi(3'd1, 3'd0, rand5());
      emitAddi(3'd2, 3'd0, rand5());
      emitAddi(3'd3, 3'd0, rand5());
      emitAddi(3'd0, 3'd0, rand5());  // r0 holds data like any other
      emitR(procPkg::ADD, 3'd4, 3'd1, 3'd2);
      emitR(procPkg::SUB, 3'd5, 3'd1, 3'd2);
      emitR(procPkg::AND, 3'd6, 3'd2, 3'd3);
      emitR(procPkg::XOR, 3'd7, 3'd1, 3'd3);
      emitR(procPkg::ADD, 3'd1, 3'd0, 3'd7);
      emitHalt();
      runProgram("alu", 1'b0);
   endtask

   task automatic testDependences();
      startTest();
      emitAddi(3'd1, 3'd0, rand5());
      emitAddi(3'd2, 3'd1, rand5());  // distance 1
      emitAddi(3'd3, 3'd0, rand5());
      emitR(procPkg::ADD, 3'd4, 3'd2, 3'd3);  // r2 at 2, r3 at 1
      emitNop();
      emitNop();
      emitR(procPkg::XOR, 3'd5, 3'd4, 3'd1);  // r4 at 3
      emitR(procPkg::SUB, 3'd5, 3'd5, 3'd2);
      emitAddi(3'd6, 3'd5, rand5());
      emitNop();
      emitR(procPkg::AND, 3'd7, 3'd6, 3'd5);
      emitHalt();
      runProgram("dependences", 1'b0);
   endtask

   task automatic testMemory();
      startTest();
      emitAddi(3'd1, 3'd0, 5'd8);  // base address
      emitAddi(3'd2, 3'd0, rand5());
      emitAddi(3'd3, 3'd0, rand5());
      emitR(procPkg::ADD, 3'd4, 3'd2, 3'd3);
      emitSt(3'd2, 3'd1, 5'd0);
      emitSt(3'd3, 3'd1, 5'd2);
      emitSt(3'd4, 3'd1, 5'd4);
      emitSt(3'd1, 3'd1, 5'h18);  // -8, word 0
      emitLd(3'd5, 3'd1, 5'd0);
      emitLd(3'd6, 3'd1, 5'd2);
      emitLd(3'd7, 3'd1, 5'd4);
      emitLd(3'd2, 3'd1, 5'h18);
      emitR(procPkg::ADD, 3'd3, 3'd5, 3'd7);  // load-use
      emitHalt();
      runProgram("memory", 1'b0);
   endtask

   task automatic testControlFlow();
      logic tk;
      startTest();
      emitAddi(3'd1, 3'd0, 5'd0);
      emitAddi(3'd2, 3'd0, rand5() | 5'd1);  // never zero
      emitBranch(procPkg::BEQZ, 3'd1, 3, tk);
      pathAddi(tk, 3'd3, 3'd0, 5'd7);
      pathAddi(tk, 3'd4, 3'd0, 5'd9);
      pathAddi(tk, 3'd5, 3'd0, 5'd11);
      emitAddi(3'd3, 3'd0, 5'd1);
      emitBranch(procPkg::BNEZ, 3'd1, 2, tk);
      pathAddi(tk, 3'd4, 3'd0, 5'd2);
      pathAddi(tk, 3'd5, 3'd0, 5'd3);
      emitBranch(procPkg::BNEZ, 3'd2, 3, tk);
      pathAddi(tk, 3'd6, 3'd0, 5'd13);
      pathAddi(tk, 3'd7, 3'd0, 5'd14);
      pathAddi(tk, 3'd1, 3'd0, 5'd15);
      emitAddi(3'd6, 3'd0, 5'd4);
      emitBranch(procPkg::BEQZ, 3'd2, 1, tk);
      pathAddi(tk, 3'd7, 3'd0, 5'd6);
      emitJump(4);
      deadAddi(3'd1, 3'd0, 5'h1f);
      deadAddi(3'd2, 3'd0, 5'h1e);
      deadAddi(3'd3, 3'd0, 5'h1d);
      deadAddi(3'd4, 3'd0, 5'h1c);
      emitAddi(3'd1, 3'd1, 5'h1d);
      emitBranch(procPkg::BNEZ, 3'd1, 1, tk);  // target lands inside the shadow
      pathAddi(tk, 3'd5, 3'd0, 5'd15);
      emitAddi(3'd7, 3'd1, 5'd2);
      emitHalt();
      runProgram("control flow", 1'b0);
   endtask

   task automatic testHalt();
      startTest();
      emitAddi(3'd1, 3'd0, 5'd3);
      emitAddi(3'd2, 3'd1, rand5());
      emitHalt();
      deadAddi(3'd3, 3'd0, 5'd1);
      deadAddi(3'd4, 3'd0, 5'd2);
      runProgram("halt", 1'b0);
   endtask

   task automatic testIllegal();
      startTest();
      emitAddi(3'd1, 3'd0, 5'd5);
      prog.push_back({5'd31, 11'h2a5});  // unused opcode
      emitAddi(3'd2, 3'd1, rand5());
      emitR(procPkg::XOR, 3'd3, 3'd2, 3'd1);
      emitHalt();
      runProgram("illegal opcode", 1'b1);
   endtask

   initial begin
      rstN     = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      testAlu();
      testDependences();
      testMemory();
      testControlFlow();
      testHalt();
      testIllegal();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
common/procPkg.sv
fetch/instMem.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
memory/memStage.sv
hdl/proc.sv
dv/procTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module procTb -f list.f -o procSim \
   && ./obj_dir/procSim | tee /dev/stderr | grep -q "^TB PASSED$" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
